//--- rvv_consts.svh
`ifndef RVV_CONSTS_SVH
`define RVV_CONSTS_SVH

// vector register length in bits.
`define RVV_VLEN 128

// fixed element width.
`define RVV_SEW 32

// lanes per register, VLEN / SEW.
`define RVV_ELEMS 4

// architectural vector registers.
`define RVV_NREGS 32

// command fifo entries, power of two.
`define RVV_QDEPTH 4

`endif // RVV_CONSTS_SVH

//--- rvv_pkg.sv
`default_nettype none

`include "rvv_consts.svh"

package rvv_pkg;

  typedef logic [`RVV_VLEN-1:0] vreg_t;
  typedef logic [`RVV_SEW-1:0] elem_t;
  typedef logic [$clog2(`RVV_NREGS)-1:0] reg_idx_t;
  typedef logic [31:0] inst_word_t;

  // what the scalar core hands over.
  typedef struct packed {
    inst_word_t inst;
    elem_t      rs1_val;
  } rvv_cmd_t;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    MVVX, // vmv.v.x splat.
    MVXS  // vmv.x.s, element 0 to scalar.
  } alu_op_t;

  // decoded fields, decode to execute.
  typedef struct packed {
    alu_op_t  op;
    reg_idx_t vd;         // rd for MVXS.
    reg_idx_t vs1;
    reg_idx_t vs2;
    logic     scalar_op;  // second operand from rs1.
    elem_t    scalar;
  } rvv_uop_t;

  // execute to result.
  typedef struct packed {
    reg_idx_t vd;
    vreg_t    vdata;
    elem_t    sdata;
    logic     to_scalar;
  } rvv_res_t;

endpackage

`default_nettype wire

//--- rvv_inst_queue.sv
`default_nettype none

`include "rvv_consts.svh"

module rvv_inst_queue
  import rvv_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  rvv_cmd_t in_cmd,
  output logic     in_ready,
  output logic     out_valid,
  output rvv_cmd_t out_cmd,
  input  logic     out_ready
);

  localparam int PW = $clog2(`RVV_QDEPTH);

  rvv_cmd_t      mem [`RVV_QDEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic [PW:0]   count_nxt;
  logic          push;
  logic          pop;

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_comb begin
    count_nxt = count;
    if (push && !pop) begin
      count_nxt = count + 1'b1;
    end else if (pop && !push) begin
      count_nxt = count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // wraps at depth.
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count    <= count_nxt;
      in_ready <= count_nxt != (PW+1)'(`RVV_QDEPTH); // ready one cycle late.
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_cmd;
  end

  assign out_valid = count != '0;
  assign out_cmd   = mem[rd_ptr];

endmodule

`default_nettype wire

//--- rvv_decode.sv
`default_nettype none

module rvv_decode
  import rvv_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       cmd_valid,
  input  rvv_cmd_t   cmd,
  output logic       cmd_ready,
  input  logic       stall,
  input  logic       ex_busy,
  input  reg_idx_t   ex_vd,
  input  logic       rs_busy,
  input  reg_idx_t   rs_vd,
  output reg_idx_t   rd_addr1,
  output reg_idx_t   rd_addr2,
  output logic       issue_valid,
  output rvv_uop_t   uop,
  output logic       trap,
  output inst_word_t trap_inst
);

  logic [5:0] funct6;
  logic       vm;
  reg_idx_t   vs2_f;
  reg_idx_t   vs1_f;
  logic [2:0] funct3;
  reg_idx_t   vd_f;
  logic [6:0] opcode;
  logic       legal;
  logic       use_vs1;
  logic       use_vs2;
  logic       hit1;
  logic       hit2;
  logic       hazard;
  logic       drop;
  alu_op_t    op;

  assign {funct6, vm, vs2_f, vs1_f, funct3, vd_f, opcode} = cmd.inst;

  always_comb begin
    legal   = 1'b0;
    use_vs1 = 1'b0;
    use_vs2 = 1'b0;
    op      = ADD;
    if (opcode == 7'b1010111 && vm) begin
      case (funct3)
        3'b000, 3'b100: begin // OPIVV, OPIVX.
          legal   = 1'b1;
          use_vs2 = 1'b1;
          use_vs1 = funct3 == 3'b000;
          case (funct6)
            6'b000000: op = ADD;
            6'b000010: op = SUB;
            6'b001001: op = AND;
            6'b001010: op = OR;
            6'b001011: op = XOR;
            6'b010111: begin
              op      = MVVX;
              use_vs2 = 1'b0;
              legal   = funct3 == 3'b100 && vs2_f == '0;
            end
            default: legal = 1'b0;
          endcase
        end
        3'b010: begin // OPMVV.
          op      = MVXS;
          use_vs2 = 1'b1;
          legal   = funct6 == 6'b010000 && vs1_f == '0;
        end
        default: legal = 1'b0;
      endcase
    end
  end

  // only vector writes ahead count.
  assign hit1   = (ex_busy && ex_vd == vs1_f) || (rs_busy && rs_vd == vs1_f);
  assign hit2   = (ex_busy && ex_vd == vs2_f) || (rs_busy && rs_vd == vs2_f);
  assign hazard = (use_vs1 && hit1) || (use_vs2 && hit2);

  assign drop        = cmd_valid & ~legal & ~stall;
  assign issue_valid = cmd_valid & legal & ~stall & ~hazard;
  assign cmd_ready   = issue_valid | drop;

  assign rd_addr1 = vs1_f;
  assign rd_addr2 = vs2_f;

  always_comb begin
    uop.op        = op;
    uop.vd        = vd_f;
    uop.vs1       = vs1_f;
    uop.vs2       = vs2_f;
    uop.scalar_op = funct3 == 3'b100;
    uop.scalar    = cmd.rs1_val;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trap <= 1'b0;
    end else begin
      trap <= drop; // one pulse per dropped word.
    end
  end

  always_ff @(posedge clk) begin
    if (drop) trap_inst <= cmd.inst;
  end

endmodule

`default_nettype wire

//--- rvv_vrf.sv
`default_nettype none

`include "rvv_consts.svh"

module rvv_vrf
  import rvv_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t rd_addr1,
  input  reg_idx_t rd_addr2,
  output vreg_t    rd_data1,
  output vreg_t    rd_data2,
  input  logic     wr_en,
  input  reg_idx_t wr_addr,
  input  vreg_t    wr_data
);

  vreg_t regs [`RVV_NREGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RVV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // no bypass, decode waits on hazards.
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

//--- rvv_execute.sv
`default_nettype none

`include "rvv_consts.svh"

module rvv_execute
  import rvv_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     issue_valid,
  input  rvv_uop_t uop,
  input  vreg_t    src1,
  input  vreg_t    src2,
  input  logic     stall,
  output logic     res_valid,
  output rvv_res_t res,
  output logic     busy,
  output reg_idx_t busy_vd
);

  vreg_t    vdata;
  elem_t    opa;
  elem_t    opb;
  rvv_res_t res_nxt;

  always_comb begin
    vdata = '0;
    for (int i = 0; i < `RVV_ELEMS; i++) begin
      opa = src2[i*`RVV_SEW +: `RVV_SEW];
      opb = uop.scalar_op ? uop.scalar : src1[i*`RVV_SEW +: `RVV_SEW];
      case (uop.op)
        ADD:     vdata[i*`RVV_SEW +: `RVV_SEW] = opa + opb;
        SUB:     vdata[i*`RVV_SEW +: `RVV_SEW] = opa - opb; // vs2 - op.
        AND:     vdata[i*`RVV_SEW +: `RVV_SEW] = opa & opb;
        OR:      vdata[i*`RVV_SEW +: `RVV_SEW] = opa | opb;
        XOR:     vdata[i*`RVV_SEW +: `RVV_SEW] = opa ^ opb;
        MVVX:    vdata[i*`RVV_SEW +: `RVV_SEW] = uop.scalar;
        default: vdata[i*`RVV_SEW +: `RVV_SEW] = opa;
      endcase
    end
  end

  always_comb begin
    res_nxt.vd        = uop.vd;
    res_nxt.vdata     = vdata;
    res_nxt.sdata     = src2[`RVV_SEW-1:0]; // element 0.
    res_nxt.to_scalar = uop.op == MVXS;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else if (!stall) begin
      res_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && issue_valid) res <= res_nxt;
  end

  assign busy    = res_valid & ~res.to_scalar;
  assign busy_vd = res.vd;

endmodule

`default_nettype wire

//--- rvv_result.sv
`default_nettype none

module rvv_result
  import rvv_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     res_valid,
  input  rvv_res_t res,
  output logic     stall,
  output logic     wr_en,
  output reg_idx_t wr_addr,
  output vreg_t    wr_data,
  output logic     busy,
  output reg_idx_t busy_vd,
  output logic     wb_event,
  output reg_idx_t wb_vd,
  output vreg_t    wb_data,
  output logic     xrf_valid,
  output reg_idx_t xrf_rd,
  output elem_t    xrf_data,
  input  logic     xrf_ready
);

  logic     valid_q;
  rvv_res_t res_q;

  // scalar result waiting on the core.
  assign stall = xrf_valid & ~xrf_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= res_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && res_valid) res_q <= res;
  end

  // vector results retire in a single cycle.
  assign wr_en   = valid_q & ~res_q.to_scalar;
  assign wr_addr = res_q.vd;
  assign wr_data = res_q.vdata;

  assign busy    = wr_en;
  assign busy_vd = res_q.vd;

  assign wb_event = wr_en;
  assign wb_vd    = res_q.vd;
  assign wb_data  = res_q.vdata;

  assign xrf_valid = valid_q & res_q.to_scalar;
  assign xrf_rd    = res_q.vd;
  assign xrf_data  = res_q.sdata;

endmodule

`default_nettype wire

//--- rvv_backend.sv
`default_nettype none

module rvv_backend
  import rvv_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       cmd_valid,
  input  rvv_cmd_t   cmd,
  output logic       cmd_ready,
  output logic       xrf_valid,
  output reg_idx_t   xrf_rd,
  output elem_t      xrf_data,
  input  logic       xrf_ready,
  output logic       wb_event,
  output reg_idx_t   wb_vd,
  output vreg_t      wb_data,
  output logic       trap,
  output inst_word_t trap_inst
);

  logic     q_valid;
  rvv_cmd_t q_cmd;
  logic     q_ready;
  reg_idx_t rd_addr1;
  reg_idx_t rd_addr2;
  vreg_t    rd_data1;
  vreg_t    rd_data2;
  logic     issue_valid;
  rvv_uop_t uop;
  logic     res_valid;
  rvv_res_t res;
  logic     stall;
  logic     ex_busy;
  reg_idx_t ex_vd;
  logic     rs_busy;
  reg_idx_t rs_vd;
  logic     wr_en;
  reg_idx_t wr_addr;
  vreg_t    wr_data;

  rvv_inst_queue queue_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (cmd_valid),
    .in_cmd    (cmd),
    .in_ready  (cmd_ready),
    .out_valid (q_valid),
    .out_cmd   (q_cmd),
    .out_ready (q_ready)
  );

  rvv_decode decode_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_valid   (q_valid),
    .cmd         (q_cmd),
    .cmd_ready   (q_ready),
    .stall       (stall),
    .ex_busy     (ex_busy),
    .ex_vd       (ex_vd),
    .rs_busy     (rs_busy),
    .rs_vd       (rs_vd),
    .rd_addr1    (rd_addr1),
    .rd_addr2    (rd_addr2),
    .issue_valid (issue_valid),
    .uop         (uop),
    .trap        (trap),
    .trap_inst   (trap_inst)
  );

  rvv_vrf vrf_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .rd_addr1 (rd_addr1),
    .rd_addr2 (rd_addr2),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rvv_execute execute_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .uop         (uop),
    .src1        (rd_data1),
    .src2        (rd_data2),
    .stall       (stall),
    .res_valid   (res_valid),
    .res         (res),
    .busy        (ex_busy),
    .busy_vd     (ex_vd)
  );

  rvv_result result_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .res_valid (res_valid),
    .res       (res),
    .stall     (stall),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .busy      (rs_busy),
    .busy_vd   (rs_vd),
    .wb_event  (wb_event),
    .wb_vd     (wb_vd),
    .wb_data   (wb_data),
    .xrf_valid (xrf_valid),
    .xrf_rd    (xrf_rd),
    .xrf_data  (xrf_data),
    .xrf_ready (xrf_ready)
  );

endmodule

`default_nettype wire

//--- rvv_backend_sva.sv
`default_nettype none

module rvv_backend_sva
  import rvv_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input logic     cmd_ready,
  input logic     xrf_valid,
  input logic     xrf_ready,
  input reg_idx_t xrf_rd,
  input elem_t    xrf_data,
  input logic     wb_event,
  input logic     trap,
  input logic     q_valid,
  input logic     q_ready,
  input logic     issue_valid,
  input logic     res_valid,
  input logic     stall
);

  // async reset, sampled mid-cycle.
  reset_quiet: assert property (@(negedge clk)
    !arst_n |-> !cmd_ready && !xrf_valid && !wb_event && !trap)
    else $error("outputs active while in reset");

  xrf_hold: assert property (@(posedge clk) disable iff (!arst_n)
    xrf_valid && !xrf_ready |=> xrf_valid && $stable(xrf_data) && $stable(xrf_rd))
    else $error("scalar return changed before ready");

  trap_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    trap |-> $past(q_valid && q_ready && !issue_valid))
    else $error("trap without a dropped word");

  wb_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    wb_event |-> $past(res_valid && !stall))
    else $error("wb_event without a new result");

endmodule

bind rvv_backend rvv_backend_sva sva_i (.*);

`default_nettype wire

//--- rvv_backend_tb.sv
`default_nettype none

`include "rvv_consts.svh"

module rvv_backend_tb
  import rvv_pkg::*;
();

  localparam int TIMEOUT = 200;

  localparam logic [1:0] K_VEC  = 2'd0;
  localparam logic [1:0] K_SCL  = 2'd1;
  localparam logic [1:0] K_TRAP = 2'd2;

  localparam logic [5:0] F_ADD = 6'b000000;
  localparam logic [5:0] F_SUB = 6'b000010;
  localparam logic [5:0] F_AND = 6'b001001;
  localparam logic [5:0] F_OR  = 6'b001010;
  localparam logic [5:0] F_XOR = 6'b001011;
  localparam logic [5:0] F_MVV = 6'b010111;

  typedef struct packed {
    logic [1:0] kind;
    inst_word_t inst;
    elem_t      rs1;
  } stim_t;

  typedef struct packed {
    logic     is_scalar;
    reg_idx_t idx;
    vreg_t    data;
  } ret_t;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       cmd_valid;
  rvv_cmd_t   cmd;
  logic       cmd_ready;
  logic       xrf_valid;
  reg_idx_t   xrf_rd;
  elem_t      xrf_data;
  logic       xrf_ready = 1'b0;
  logic       wb_event;
  reg_idx_t   wb_vd;
  vreg_t      wb_data;
  logic       trap;
  inst_word_t trap_inst;

  stim_t      stim [$];
  ret_t       ret_q [$];
  inst_word_t trap_q [$];
  vreg_t      model [`RVV_NREGS];
  integer     seed = 32'hdbbd;
  int         mism_cnt = 0;
  int         fail_cnt = 0;

  rvv_backend dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .xrf_valid (xrf_valid),
    .xrf_rd    (xrf_rd),
    .xrf_data  (xrf_data),
    .xrf_ready (xrf_ready),
    .wb_event  (wb_event),
    .wb_vd     (wb_vd),
    .wb_data   (wb_data),
    .trap      (trap),
    .trap_inst (trap_inst)
  );

  always #50 clk = ~clk;

  // core side back-pressure.
  always @(posedge clk) begin
    int rnd;
    rnd = $random(seed);
    xrf_ready <= rnd[0];
  end

  function automatic inst_word_t vv(logic [5:0] f6, int vd, int vs2, int vs1);
    return {f6, 1'b1, vs2[4:0], vs1[4:0], 3'b000, vd[4:0], 7'b1010111};
  endfunction

  function automatic inst_word_t vx(logic [5:0] f6, int vd, int vs2);
    return {f6, 1'b1, vs2[4:0], 5'd1, 3'b100, vd[4:0], 7'b1010111};
  endfunction

  function automatic inst_word_t mvxs(int rd, int vs2);
    return {6'b010000, 1'b1, vs2[4:0], 5'd0, 3'b010, rd[4:0], 7'b1010111};
  endfunction

  function automatic vreg_t expect_vec(inst_word_t w, elem_t x);
    vreg_t a;
    vreg_t b;
    vreg_t r;
    elem_t ea;
    elem_t eb;
    a = model[w[24:20]];
    b = (w[14:12] == 3'b100) ? {`RVV_ELEMS{x}} : model[w[19:15]];
    case (w[31:26])
      F_AND: r = a & b;
      F_OR:  r = a | b;
      F_XOR: r = a ^ b;
      F_MVV: r = {`RVV_ELEMS{x}};
      default: begin
        for (int i = 0; i < `RVV_ELEMS; i++) begin
          ea = a[i*`RVV_SEW +: `RVV_SEW];
          eb = b[i*`RVV_SEW +: `RVV_SEW];
          r[i*`RVV_SEW +: `RVV_SEW] = (w[31:26] == F_SUB) ? ea - eb : ea + eb; // wraps.
        end
      end
    endcase
    return r;
  endfunction

  task automatic add(input logic [1:0] kind, input inst_word_t w, input elem_t v);
    stim_t e;
    e.kind = kind;
    e.inst = w;
    e.rs1  = v;
    stim.push_back(e);
  endtask

  task automatic build_table();
    add(K_VEC, vx(F_MVV, 1, 0), 32'h0000_0005);
    add(K_VEC, vx(F_MVV, 2, 0), 32'hffff_fff0);
    add(K_VEC, vx(F_MVV, 3, 0), 32'h1234_5678);
    add(K_VEC, vx(F_MVV, 4, 0), 32'h8000_0001);
    add(K_VEC, vv(F_ADD, 5, 2, 1), 32'h0);
    add(K_VEC, vv(F_ADD, 6, 4, 4), 32'h0);
    add(K_VEC, vv(F_SUB, 7, 1, 2), 32'h0);
    add(K_VEC, vv(F_AND, 8, 3, 2), 32'h0);
    add(K_VEC, vv(F_OR, 9, 3, 4), 32'h0);
    add(K_VEC, vv(F_XOR, 10, 3, 2), 32'h0);
    add(K_VEC, vx(F_ADD, 11, 3), 32'h0000_1000);
    add(K_VEC, vx(F_SUB, 12, 1), 32'h0000_0007);
    add(K_VEC, vx(F_AND, 13, 10), 32'h0f0f_0f0f);
    add(K_VEC, vx(F_OR, 14, 13), 32'h8000_0000);
    add(K_VEC, vx(F_XOR, 15, 14), 32'hffff_ffff);
    add(K_VEC, vv(F_ADD, 16, 15, 15), 32'h0);
    add(K_VEC, vv(F_SUB, 16, 16, 1), 32'h0); // reads its own destination.
    add(K_SCL, mvxs(5, 16), 32'h0);
    add(K_SCL, mvxs(7, 3), 32'h0);
    add(K_SCL, mvxs(9, 12), 32'h0);
    add(K_TRAP, vv(F_ADD, 1, 2, 3) ^ 32'h0000_0004, 32'h0); // opcode 1010011.
    add(K_TRAP, vv(F_ADD, 2, 1, 1) & 32'hfdff_ffff, 32'h0); // vm cleared.
    add(K_TRAP, vv(6'b111111, 3, 1, 1), 32'h0);
    add(K_SCL, mvxs(1, 1), 32'h0);
    add(K_SCL, mvxs(2, 2), 32'h0);
    add(K_SCL, mvxs(3, 3), 32'h0);
    add(K_VEC, vv(F_XOR, 17, 2, 1), 32'h0);
    add(K_SCL, mvxs(4, 17), 32'h0);
  endtask

  task automatic predict(input stim_t e);
    ret_t r;
    r.is_scalar = e.kind == K_SCL;
    r.idx       = e.inst[11:7];
    if (e.kind == K_TRAP) begin
      trap_q.push_back(e.inst);
    end else begin
      if (e.kind == K_VEC) begin
        r.data = expect_vec(e.inst, e.rs1);
        model[r.idx] = r.data;
      end else begin
        r.data = vreg_t'(model[e.inst[24:20]][`RVV_SEW-1:0]); // element 0.
      end
      ret_q.push_back(r);
    end
  endtask

  task automatic check(input string name, input vreg_t got, input vreg_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mism_cnt++;
    end
  endtask

  task automatic retire(input logic is_scalar, input reg_idx_t idx, input vreg_t data);
    ret_t e;
    if (ret_q.size() == 0) begin
      $display("a result retired that no instruction was expected to produce");
      fail_cnt++;
    end else begin
      e = ret_q.pop_front();
      check("retire_kind", vreg_t'(is_scalar), vreg_t'(e.is_scalar));
      check(is_scalar ? "xrf_rd" : "wb_vd", vreg_t'(idx), vreg_t'(e.idx));
      check(is_scalar ? "xrf_data" : "wb_data", data, e.data);
    end
  endtask

  task automatic send(input inst_word_t w, input elem_t v);
    int t;
    t = 0;
    cmd_valid   <= 1'b1;
    cmd.inst    <= w;
    cmd.rs1_val <= v;
    @(negedge clk);
    while (!cmd_ready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!cmd_ready) begin
      $display("timed out waiting for cmd_ready on word 0x%h", w);
      fail_cnt++;
    end
    @(posedge clk);
  endtask

  task automatic drain();
    int t;
    t = 0;
    while ((ret_q.size() != 0 || trap_q.size() != 0) && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (ret_q.size() != 0 || trap_q.size() != 0) begin
      $display("timed out with %0d results and %0d traps still missing",
               ret_q.size(), trap_q.size());
      fail_cnt++;
    end
    repeat (4) @(negedge clk); // catch stray events.
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      if (wb_event) retire(1'b0, wb_vd, wb_data);
      if (xrf_valid && xrf_ready) retire(1'b1, xrf_rd, vreg_t'(xrf_data));
      if (trap) begin
        if (trap_q.size() == 0) begin
          $display("trap raised for a word that should have executed");
          fail_cnt++;
        end else begin
          check("trap_inst", vreg_t'(trap_inst), vreg_t'(trap_q.pop_front()));
        end
      end
    end
  end

  initial begin
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    for (int i = 0; i < `RVV_NREGS; i++) begin
      model[i] = '0;
    end
    build_table();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    foreach (stim[n]) begin
      predict(stim[n]);
      send(stim[n].inst, stim[n].rs1);
    end
    cmd_valid <= 1'b0;
    drain();
    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
rvv_pkg.sv
rvv_inst_queue.sv
rvv_decode.sv
rvv_vrf.sv
rvv_execute.sv
rvv_result.sv
rvv_backend.sv
rvv_backend_sva.sv
rvv_backend_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rvv_backend_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
	  echo "test failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
	  echo "run ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
